// ==== cache_wb.f ====
hdl/cache_wb_pkg.sv
hdl/axi_wr_pkg.sv
hdl/wr_ingress.sv
hdl/wr_buffer.sv
hdl/axi_wr_master.sv
hdl/cache_wb_top.sv
tb/tb_cache_wb.sv

// ==== Bender.yml ====
package:
  name: cache_wb

sources:
  - files:
      - hdl/cache_wb_pkg.sv
      - hdl/axi_wr_pkg.sv
      - hdl/wr_ingress.sv
      - hdl/wr_buffer.sv
      - hdl/axi_wr_master.sv
      - hdl/cache_wb_top.sv
  - target: test
    files:
      - tb/tb_cache_wb.sv

// ==== tb/tb_cache_wb.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cache_wb
    import cache_wb_pkg::*;
    import axi_wr_pkg::*;
();

    localparam int num_reqs_c = 400;
    localparam int timeout_c  = num_reqs_c * 40;
    localparam int seed_c     = 72946;

    logic    clk = 1'b0;
    logic    rst;
    logic    req_valid;
    wr_req_t req;
    logic    req_ready;
    logic    awvalid;
    axi_aw_t aw;
    logic    awready;
    logic    wvalid;
    axi_w_t  w;
    logic    wready;
    logic    bvalid;
    logic    bready;
    logic    empty;

    // request stream and bus stall stream run from the same seed.
    logic [31:0] req_seed = seed_c;
    logic [31:0] bus_seed = seed_c ^ 32'h5a5a_5a5a;

    int   errors          = 0;
    int   bursts_done     = 0;
    logic ready_fell      = 1'b0;
    logic ready_recovered = 1'b0;

    // expected bursts in acceptance order with their beats kept flat.
    addr_t      exp_addr [$];
    logic [7:0] exp_len  [$];
    axi_size_t  exp_size [$];
    word_t      exp_data [$];
    strb_t      exp_strb [$];
    logic       exp_last [$];

    cache_wb_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .awvalid   (awvalid),
        .aw        (aw),
        .awready   (awready),
        .wvalid    (wvalid),
        .w         (w),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .empty     (empty)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] req_rand();
        req_seed = lcg_step(req_seed);
        return req_seed[31:16];
    endfunction

    function automatic logic [15:0] bus_rand();
        bus_seed = lcg_step(bus_seed);
        return bus_seed[31:16];
    endfunction

    // one lane is a byte and two neighbouring lanes a half-word.
    function automatic axi_size_t store_size(input strb_t s);
        if ($countones(s) == 1) begin
            return size_byte_c;
        end
        if ($countones(s) == 2 && (s & (s >> 1)) != 4'b0) begin
            return size_half_c;
        end
        return size_word_c;
    endfunction

    function automatic logic [1:0] low_lane(input strb_t s);
        logic [1:0] lane;
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (s[i]) begin
                lane = 2'(i);
            end
        end
        return lane;
    endfunction

    // aligned strobe patterns an uncached store may carry.
    function automatic strb_t pick_strobe(input logic [15:0] x);
        case (x % 7)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            3:       return 4'b1000;
            4:       return 4'b0011;
            5:       return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic expect_request(input wr_req_t r);
        if (r.uncached) begin
            exp_addr.push_back(r.addr);
            exp_len.push_back(8'd0);
            exp_size.push_back(store_size(r.strb));
            exp_data.push_back(r.word);
            exp_strb.push_back(r.strb);
            exp_last.push_back(1'b1);
        end else begin
            exp_addr.push_back({r.addr[31:4], 4'h0});
            exp_len.push_back(8'(words_per_line_c - 1));
            exp_size.push_back(size_word_c);
            for (int k = 0; k < words_per_line_c; k++) begin
                exp_data.push_back(r.line[k*32 +: 32]);
                exp_strb.push_back(4'hf);
                exp_last.push_back(k == words_per_line_c - 1);
            end
        end
    endtask

    // request driver.
    initial begin
        wr_req_t     r;
        logic [15:0] x;
        int          gap;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_reqs_c; i++) begin
            x          = req_rand();
            r.uncached = x[0];
            r.addr     = {req_rand(), req_rand()};
            r.word     = {req_rand(), req_rand()};
            r.strb     = pick_strobe(req_rand());
            for (int k = 0; k < 8; k++) begin
                r.line[k*16 +: 16] = req_rand();
            end
            if (r.uncached) begin
                r.addr[1:0] = low_lane(r.strb);
            end
            req_valid <= 1'b1;
            req       <= r;
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
            expect_request(r);
            x   = req_rand();
            gap = x[3] ? 0 : int'(x[1:0]);
            if (gap != 0) begin
                req_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        req_valid <= 1'b0;
        wait (bursts_done == num_reqs_c);
        // idle a while so a duplicated burst would still show up.
        repeat (20) @(posedge clk);
        check_value("bursts at end", num_reqs_c, bursts_done);
        check_value("empty at end", 1, empty);
        if (exp_addr.size() != 0 || exp_data.size() != 0) begin
            flag_error("expected bursts were never seen on the bus");
        end
        if (!ready_recovered) begin
            flag_error("req_ready never fell and recovered under back-pressure");
        end
        $display("%0d errors over %0d requests", errors, num_reqs_c);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // AXI slave model and bus monitor.
    initial begin
        int          outstanding;
        int          beats_left;
        int          phase;
        logic        burst_open;
        logic        b_pending;
        logic        slow;
        logic        b_go;
        logic [15:0] x;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        outstanding = 0;
        beats_left  = 0;
        phase       = 0;
        burst_open  = 1'b0;
        b_pending   = 1'b0;
        forever begin
            @(posedge clk);
            if (!rst) begin
                check_value("empty", outstanding == 0, empty);
                if (awvalid && burst_open) begin
                    flag_error("new AW issued before the previous burst's B handshake");
                end
                if (bready && (!burst_open || beats_left != 0)) begin
                    flag_error("bready raised before the last W beat of the burst");
                end
                if (!req_ready) begin
                    ready_fell = 1'b1;
                end else if (ready_fell) begin
                    ready_recovered = 1'b1;
                end
                if (req_valid && req_ready) begin
                    outstanding++;
                end
                if (awvalid && awready) begin
                    if (exp_addr.size() == 0) begin
                        flag_error("AW burst with no accepted request behind it");
                    end else begin
                        beats_left = exp_len[0] + 1;
                        burst_open = 1'b1;
                        check_value("awaddr", exp_addr.pop_front(), aw.awaddr);
                        check_value("awlen", exp_len.pop_front(), aw.awlen);
                        check_value("awsize", exp_size.pop_front(), aw.awsize);
                    end
                end
                if (wvalid && wready) begin
                    if (!burst_open || beats_left == 0 || exp_data.size() == 0) begin
                        flag_error("W beat outside an open burst");
                    end else begin
                        check_value("wdata", exp_data.pop_front(), w.wdata);
                        check_value("wstrb", exp_strb.pop_front(), w.wstrb);
                        check_value("wlast", exp_last.pop_front(), w.wlast);
                        beats_left--;
                        if (beats_left == 0) begin
                            b_pending = 1'b1;
                        end
                    end
                end
                if (bvalid && bready) begin
                    burst_open = 1'b0;
                    outstanding--;
                    bursts_done++;
                end

                // slow and fast stretches of 256 cycles each.
                phase++;
                slow = (phase % 512) >= 256;
                x    = bus_rand();
                b_go = slow ? (x[8:6] == 3'd0) : (x[8:6] != 3'd0);
                awready <= slow ? (x[2:0] == 3'd0) : (x[2:0] != 3'd0);
                wready  <= slow ? (x[5:3] == 3'd0) : (x[5:3] != 3'd0);
                if (bvalid && bready) begin
                    bvalid <= 1'b0;
                end else if (b_pending && b_go) begin
                    bvalid    <= 1'b1;
                    b_pending = 1'b0;
                end
            end
        end
    end

    // run limit.
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < timeout_c) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d bursts completed",
                 cycles, bursts_done, num_reqs_c);
        $display("%0d errors before the timeout", errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_wb_top
    import cache_wb_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    req_valid,
    input  wire wr_req_t req,
    output logic         req_ready,

    output logic         awvalid,
    output axi_aw_t      aw,
    input  wire logic    awready,
    output logic         wvalid,
    output axi_w_t       w,
    input  wire logic    wready,
    input  wire logic    bvalid,
    output logic         bready,

    output logic         empty
);

    logic    ing_valid;
    wr_cmd_t ing_cmd;
    logic    ing_ready;
    logic    buf_valid;
    wr_cmd_t buf_cmd;
    logic    buf_ready;
    logic    buf_empty;
    logic    busy;

    wr_ingress i_ingress (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .ing_valid (ing_valid),
        .ing_cmd   (ing_cmd),
        .ing_ready (ing_ready)
    );

    wr_buffer i_buffer (
        .clk       (clk),
        .rst       (rst),
        .ing_valid (ing_valid),
        .ing_cmd   (ing_cmd),
        .ing_ready (ing_ready),
        .buf_valid (buf_valid),
        .buf_cmd   (buf_cmd),
        .buf_ready (buf_ready),
        .buf_empty (buf_empty)
    );

    axi_wr_master i_master (
        .clk       (clk),
        .rst       (rst),
        .buf_valid (buf_valid),
        .buf_cmd   (buf_cmd),
        .buf_ready (buf_ready),
        .awvalid   (awvalid),
        .aw        (aw),
        .awready   (awready),
        .wvalid    (wvalid),
        .w         (w),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .busy      (busy)
    );

    // nothing held in any stage and no burst waiting for its response.
    assign empty = !ing_valid && buf_empty && !busy;

endmodule

`default_nettype wire

// ==== hdl/axi_wr_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_wr_master
    import cache_wb_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    buf_valid,
    input  wire wr_cmd_t buf_cmd,
    output logic         buf_ready,

    output logic         awvalid,
    output axi_aw_t      aw,
    input  wire logic    awready,

    output logic         wvalid,
    output axi_w_t       w,
    input  wire logic    wready,

    input  wire logic    bvalid,
    output logic         bready,

    output logic         busy
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t     state;
    wr_cmd_t    cmd_q;
    logic [7:0] beat;
    logic       last_beat;

    // pop pulse, the command is taken on this edge.
    assign buf_ready = (state == IDLE) && buf_valid;
    assign busy      = state != IDLE;
    assign last_beat = beat == cmd_q.len;

    assign awvalid   = state == ADDR;
    assign aw.awaddr = cmd_q.addr;
    assign aw.awlen  = cmd_q.len;
    assign aw.awsize = cmd_q.size;

    // one payload word per beat, lowest word first.
    assign wvalid  = state == DATA;
    assign w.wdata = cmd_q.payload[beat*$bits(word_t) +: $bits(word_t)];
    assign w.wstrb = cmd_q.uncached ? cmd_q.strb : '1;
    assign w.wlast = last_beat;

    assign bready = state == RESP;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (buf_valid) begin
                        state <= ADDR;
                        beat  <= '0;
                    end
                end
                ADDR: begin
                    if (awready) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (wready) begin
                        if (last_beat) begin
                            state <= RESP;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                RESP: begin
                    // response code is not checked.
                    if (bvalid) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (buf_ready) begin
            cmd_q <= buf_cmd;
        end
    end

    a_aw_stable : assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW changed before awready");

    a_w_stable : assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W changed before wready");

    // ingress never builds a burst longer than one line.
    a_len_fits : assert property (@(posedge clk) disable iff (rst)
        buf_ready |-> buf_cmd.len < words_per_line_c)
        else $error("burst length exceeds line");

endmodule

`default_nettype wire

// ==== hdl/wr_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module wr_buffer
    import cache_wb_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    ing_valid,
    input  wire wr_cmd_t ing_cmd,
    output logic         ing_ready,

    output logic         buf_valid,
    output wr_cmd_t      buf_cmd,
    input  wire logic    buf_ready,
    output logic         buf_empty
);

    wr_cmd_t                         mem [wb_depth_c];
    logic [$clog2(wb_depth_c)-1:0]   wr_ptr;
    logic [$clog2(wb_depth_c)-1:0]   rd_ptr;
    logic [$clog2(wb_depth_c+1)-1:0] count;
    logic                            push;
    logic                            pop;

    assign ing_ready = count != wb_depth_c;
    assign buf_valid = count != '0;
    assign buf_empty = count == '0;
    assign buf_cmd   = mem[rd_ptr];

    assign push = ing_valid && ing_ready;
    assign pop  = buf_ready && buf_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= ing_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == wb_depth_c - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == wb_depth_c - 1) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // occupancy, push and pop may land on the same edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a command offered while full waits in ingress, so nothing is lost.
    a_no_push_full : assert property (@(posedge clk) disable iff (rst)
        ing_valid && !ing_ready |=> ing_valid && $stable(ing_cmd))
        else $error("command dropped while buffer full");

    // the master only pops an entry that is there.
    a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
        buf_ready |-> buf_valid)
        else $error("pop from empty write buffer");

endmodule

`default_nettype wire

// ==== hdl/wr_ingress.sv ====
`timescale 1ns/10ps
`default_nettype none

module wr_ingress
    import cache_wb_pkg::*;
    import axi_wr_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,

    input  wire logic    req_valid,
    input  wire wr_req_t req,
    output logic         req_ready,

    output logic         ing_valid,
    output wr_cmd_t      ing_cmd,
    input  wire logic    ing_ready
);

    logic      take;
    axi_size_t store_size;
    wr_cmd_t   next_cmd;

    // the output register takes a new request while it drains the old one.
    assign req_ready = !ing_valid || ing_ready;
    assign take      = req_valid && req_ready;

    // beat size of an uncached store follows its strobe pattern.
    always_comb begin
        case (req.strb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: store_size = size_byte_c;
            4'b0011, 4'b0110, 4'b1100:          store_size = size_half_c;
            default:                            store_size = size_word_c;
        endcase
    end

    always_comb begin
        next_cmd.uncached = req.uncached;
        next_cmd.strb     = req.strb;
        if (req.uncached) begin
            next_cmd.addr    = req.addr;
            next_cmd.len     = 8'd0;
            next_cmd.size    = store_size;
            next_cmd.payload = line_t'(req.word);
        end else begin
            // evictions start on the line boundary.
            next_cmd.addr    = req.addr & ~addr_t'(line_bytes_c - 1);
            next_cmd.len     = 8'(words_per_line_c - 1);
            next_cmd.size    = size_word_c;
            next_cmd.payload = req.line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ing_valid <= 1'b0;
        end else if (take) begin
            ing_valid <= 1'b1;
        end else if (ing_ready) begin
            ing_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ing_cmd <= next_cmd;
        end
    end

    // the controller keeps a pending request unchanged until it is taken.
    a_req_hold : assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("write request changed while held");

endmodule

`default_nettype wire

// ==== hdl/axi_wr_pkg.sv ====
`default_nettype none

package axi_wr_pkg;

    localparam int addr_w_c = 32;
    localparam int data_w_c = 32;
    localparam int len_w_c  = 8;

    typedef logic [addr_w_c-1:0]   axi_addr_t;
    typedef logic [data_w_c-1:0]   axi_data_t;
    typedef logic [data_w_c/8-1:0] axi_strb_t;
    typedef logic [len_w_c-1:0]    axi_len_t;
    typedef logic [2:0]            axi_size_t;

    // awsize codes for the beat widths in use.
    localparam axi_size_t size_byte_c = 3'd0;
    localparam axi_size_t size_half_c = 3'd1;
    localparam axi_size_t size_word_c = 3'd2;

    typedef struct packed {
        axi_addr_t awaddr;
        axi_len_t  awlen;
        axi_size_t awsize;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t wdata;
        axi_strb_t wstrb;
        logic      wlast;
    } axi_w_t;

endpackage

`default_nettype wire

// ==== hdl/cache_wb_pkg.sv ====
`default_nettype none

package cache_wb_pkg;

    // geometry of one data cache line.
    localparam int line_bytes_c     = 16;
    localparam int words_per_line_c = 4;

    // entries held between ingress and the bus master.
    localparam int wb_depth_c = 4;

    typedef logic [31:0]               addr_t;
    typedef logic [31:0]               word_t;
    typedef logic [3:0]                strb_t;
    typedef logic [line_bytes_c*8-1:0] line_t;

    // write request as the cache controller offers it.
    typedef struct packed {
        logic  uncached;
        addr_t addr;
        word_t word;
        strb_t strb;
        line_t line;
    } wr_req_t;

    // burst command as it waits in the write buffer.
    // strb only matters for an uncached store.
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        logic       uncached;
        strb_t      strb;
        line_t      payload;
    } wr_cmd_t;

endpackage

`default_nettype wire
